// ==== hdl/keccak_defines.svh ====
// Keccak-f[1600] and SHA3-256 sponge dimensions.
// Fixed by FIPS 202 for the SHA3-256 instance.
`ifndef KECCAK_DEFINES_SVH
`define KECCAK_DEFINES_SVH

// Permutation width in bits.
`define KECCAK_STATE_W 1600

// One lane of the 5x5 state.
`define KECCAK_LANE_W 64

// SHA3-256 rate, 17 lanes.
`define SPONGE_RATE_W 1088

// Digest width, the first 4 lanes.
`define SPONGE_DIGEST_W 256

// Rounds per permutation.
`define KECCAK_ROUNDS 24

`endif

// ==== hdl/keccak_permutation.sv ====
// Keccak-f[1600] permutation, one round per clock.
// Loads on start, runs 24 rounds and pulses done.
`timescale 1ns/10ps
`include "keccak_defines.svh"

module keccak_permutation
    import keccak_state_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  keccak_state_u init_state,
    output keccak_state_u state,
    output logic          done
);

    localparam int ROUND_CNT_W = $clog2(`KECCAK_ROUNDS);

    logic [ROUND_CNT_W-1:0] round_cnt;
    logic                   running;
    logic                   advance;
    round_const_t           round_const;
    keccak_state_u          round_out;

    // One round consumed per running cycle.
    assign advance = running;

    round_constant_gen round_constant_gen_i
    (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .advance     (advance),
        .round_const (round_const)
    );

    keccak_round keccak_round_i
    (
        .in          (state),
        .round_const (round_const),
        .out         (round_out)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= '0;
            running   <= 1'b0;
            round_cnt <= '0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                state     <= init_state;
                running   <= 1'b1;
                round_cnt <= '0;
            end
            else if (running)
            begin
                state <= round_out;
                // Last round registered, result stays until next start.
                if (round_cnt == ROUND_CNT_W'(`KECCAK_ROUNDS - 1))
                begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
                else
                    round_cnt <= round_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/keccak_round.sv ====
// One Keccak-f[1600] round, purely combinational.
// Theta, rho, pi, chi and iota on the lane view of the state.
`timescale 1ns/10ps
`include "keccak_defines.svh"

module keccak_round
    import keccak_state_pkg::*;
(
    input  keccak_state_u in,
    input  round_const_t  round_const,
    output keccak_state_u out
);

    // Rho offsets, indexed as 5*y+x.
    localparam int RHO [25] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    lane_plane_t a;
    lane_plane_t b;
    lane_plane_t e;
    lane_t       c [5];
    lane_t       d [5];

    function automatic lane_t rotl(input lane_t v, input int n);
        lane_t r;
        if (n == 0)
            r = v;
        else
            r = (v << n) | (v >> (`KECCAK_LANE_W - n));
        return r;
    endfunction

    assign a = in.lanes;

    // Theta: column parities and the mix term per column.
    always_comb
    begin
        for (int x = 0; x < 5; x++)
        begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        end
        for (int x = 0; x < 5; x++)
        begin
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
        end
    end

    // Rho and pi together, lane (x,y) moves to (y, 2x+3y).
    always_comb
    begin
        for (int y = 0; y < 5; y++)
        begin
            for (int x = 0; x < 5; x++)
            begin
                b[5*((2*x+3*y)%5) + y] = rotl(a[5*y+x] ^ d[x], RHO[5*y+x]);
            end
        end
    end

    // Chi row by row, then iota on lane (0,0).
    always_comb
    begin
        for (int y = 0; y < 5; y++)
        begin
            for (int x = 0; x < 5; x++)
            begin
                e[5*y+x] = b[5*y+x] ^ (~b[5*y+(x+1)%5] & b[5*y+(x+2)%5]);
            end
        end
        e[0] = e[0] ^ round_const;
        out.lanes = e;
    end

endmodule

// ==== hdl/keccak_sponge.sv ====
// SHA3-256 sponge core over padded 1088-bit blocks.
// Absorbs each block, permutes, and presents the digest after the last one.
`timescale 1ns/10ps
`include "keccak_defines.svh"

module keccak_sponge
    import keccak_state_pkg::*;
    import sponge_io_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  msg_block_t block,
    input  logic       block_valid,
    output logic       busy,
    output digest_t    digest,
    output logic       digest_valid
);

    localparam int RATE_LANES   = `SPONGE_RATE_W / `KECCAK_LANE_W;
    localparam int DIGEST_LANES = `SPONGE_DIGEST_W / `KECCAK_LANE_W;

    logic          start;
    logic          done;
    logic          last_pending;
    logic          chain_clear;
    keccak_state_u init_state;
    keccak_state_u state;
    digest_t       digest_next;

    // Message bytes map little-endian into each lane.
    function automatic lane_t byte_swap(input lane_t v);
        lane_t r;
        for (int n = 0; n < 8; n++)
            r[8*n +: 8] = v[56-8*n +: 8];
        return r;
    endfunction

    assign start = block_valid && !busy;

    // Absorb into the chained state, or into zero for a new message.
    always_comb
    begin
        init_state.flat = chain_clear ? '0 : state.flat;
        for (int i = 0; i < RATE_LANES; i++)
        begin
            init_state.flat[`KECCAK_STATE_W-1-`KECCAK_LANE_W*i -: `KECCAK_LANE_W] ^=
                byte_swap(block.data[`SPONGE_RATE_W-1-`KECCAK_LANE_W*i -: `KECCAK_LANE_W]);
        end
    end

    // Digest is the first four lanes in byte order.
    always_comb
    begin
        for (int i = 0; i < DIGEST_LANES; i++)
        begin
            digest_next.hash[`SPONGE_DIGEST_W-1-`KECCAK_LANE_W*i -: `KECCAK_LANE_W] =
                byte_swap(state.flat[`KECCAK_STATE_W-1-`KECCAK_LANE_W*i -: `KECCAK_LANE_W]);
        end
    end

    keccak_permutation keccak_permutation_i
    (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .init_state (init_state),
        .state      (state),
        .done       (done)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy         <= 1'b0;
            digest_valid <= 1'b0;
            last_pending <= 1'b0;
            chain_clear  <= 1'b1;
        end
        else
        begin
            digest_valid <= 1'b0;
            if (start)
            begin
                busy         <= 1'b1;
                last_pending <= block.last;
                chain_clear  <= 1'b0;
            end
            else if (done)
            begin
                busy <= 1'b0;
                if (last_pending)
                begin
                    digest_valid <= 1'b1;
                    chain_clear  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (done && last_pending)
            digest <= digest_next;
    end

endmodule

// ==== hdl/keccak_state_pkg.sv ====
// Keccak state types.
// One lane, the 5x5 lane plane and the two views of the full state.
`include "keccak_defines.svh"

package keccak_state_pkg;

    // One 64-bit lane, bit z of the lane at index z.
    typedef logic [`KECCAK_LANE_W-1:0] lane_t;

    // Lanes indexed as 5*y+x, lane (0,0) in the top bits.
    typedef lane_t [0:24] lane_plane_t;

    // Full state, flat for rate and digest access, lanes for the round.
    typedef union packed
    {
        logic [`KECCAK_STATE_W-1:0] flat;
        lane_plane_t lanes;
    } keccak_state_u;

    // Iota constant for one round.
    typedef logic [`KECCAK_LANE_W-1:0] round_const_t;

endpackage

// ==== hdl/round_constant_gen.sv ====
// Iota round constant generator.
// LFSR x^8+x^6+x^5+x^4+1, seven outputs spent per round.
`timescale 1ns/10ps

module round_constant_gen
    import keccak_state_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         advance,
    output round_const_t round_const
);

    logic [7:0] lfsr;
    logic [7:0] lfsr_next;

    // Unroll the seven LFSR steps of the current round.
    always_comb
    begin
        logic [7:0] v;
        v = lfsr;
        round_const = '0;
        for (int j = 0; j < 7; j++)
        begin
            round_const[(1 << j) - 1] = v[0];
            // Galois form of the feedback, taps 0x71.
            if (v[7])
                v = {v[6:0], 1'b0} ^ 8'h71;
            else
                v = {v[6:0], 1'b0};
        end
        lfsr_next = v;
    end

    always_ff @(posedge clk)
    begin
        if (rst || start)
            lfsr <= 8'h01;
        else if (advance)
            lfsr <= lfsr_next;
    end

endmodule

// ==== hdl/sponge_io_pkg.sv ====
// Sponge port types.
// Incoming padded message block and outgoing digest.
`include "keccak_defines.svh"

package sponge_io_pkg;

    // Padded block, message byte 0 in the top bits of data.
    typedef struct packed
    {
        logic [`SPONGE_RATE_W-1:0] data;
        logic last;
    } msg_block_t;

    // Digest, byte 0 in the top bits as in the usual hex string.
    typedef struct packed
    {
        logic [`SPONGE_DIGEST_W-1:0] hash;
    } digest_t;

endpackage

// ==== keccak_sponge.f ====
+incdir+hdl
hdl/keccak_state_pkg.sv
hdl/sponge_io_pkg.sv
hdl/keccak_round.sv
hdl/round_constant_gen.sv
hdl/keccak_permutation.sv
hdl/keccak_sponge.sv
verification/keccak_sponge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the keccak_sponge testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module keccak_sponge_tb \
    -f keccak_sponge.f -o keccak_sponge_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/keccak_sponge_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi
exit 0

// ==== verification/keccak_sponge_tb.sv ====
// Testbench for the SHA3-256 sponge core.
// Replays padded blocks from the vector file, checks digests and busy timing.
`timescale 1ns/10ps
`include "keccak_defines.svh"

module keccak_sponge_tb
    import sponge_io_pkg::*;
();

    localparam int RATE_LANES   = `SPONGE_RATE_W / `KECCAK_LANE_W;
    localparam int DIGEST_LANES = `SPONGE_DIGEST_W / `KECCAK_LANE_W;
    localparam int VEC_DEPTH    = 256;

    logic       clk = 1'b0;
    logic       rst;
    msg_block_t block;
    logic       block_valid;
    logic       busy;
    digest_t    digest;
    logic       digest_valid;

    logic [63:0] vec [0:VEC_DEPTH-1];
    int          cycle_cnt = 0;
    int          cycle_limit = 200;
    int          digests_expected = 0;
    int          digests_checked = 0;

    keccak_sponge keccak_sponge_i
    (
        .clk          (clk),
        .rst          (rst),
        .block        (block),
        .block_valid  (block_valid),
        .busy         (busy),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Bound on the run. Raised once the block count is known.
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout, the test did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERROR %0t %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_digest(input digest_t expected, input digest_t actual);
        if (actual !== expected)
        begin
            $display("ERROR %0t digest expected %h actual %h", $time, expected.hash, actual.hash);
            abort_run();
        end
    endtask

    // One cycle with outputs sampled at the falling edge.
    task automatic tick(input logic exp_busy, input logic exp_valid);
        @(negedge clk);
        check_level("busy", exp_busy, busy);
        check_level("digest_valid", exp_valid, digest_valid);
    endtask

    // Idle gap, accept edge, 24 round edges, then the release edge.
    task automatic send_block(input msg_block_t blk, input digest_t expected);
        int         gap;
        int         junk_at;
        msg_block_t junk;
        gap     = int'($urandom % 6);
        junk_at = 1 + int'($urandom % 23);
        repeat (gap) tick(1'b0, 1'b0);
        block       = blk;
        block_valid = 1'b1;
        tick(1'b1, 1'b0);
        block_valid = 1'b0;
        for (int j = 1; j <= 24; j++)
        begin
            tick(1'b1, 1'b0);
            // Garbage strobe while busy must be ignored.
            block_valid = (j == junk_at);
            if (j == junk_at)
            begin
                for (int i = 0; i < `SPONGE_RATE_W / 32; i++)
                    junk.data[32*i +: 32] = $urandom;
                junk.last = 1'($urandom % 2);
                block     = junk;
            end
        end
        tick(1'b0, blk.last);
        if (blk.last)
        begin
            check_digest(expected, digest);
            digests_checked++;
        end
    endtask

    initial
    begin
        int         p;
        int         n_blocks;
        logic [7:0] hdr;
        msg_block_t blk;
        digest_t    expected;
        void'($urandom(32'hac73_e09f));
        rst         = 1'b1;
        block       = '0;
        block_valid = 1'b0;
        foreach (vec[i])
            vec[i] = '0;
        $readmemh("verification/keccak_sponge_vectors.txt", vec);

        // Count records to size the timeout.
        p        = 0;
        n_blocks = 0;
        while (p < VEC_DEPTH && vec[p][7:0] != 8'h00)
        begin
            if (vec[p][7:0] == 8'h02)
            begin
                digests_expected++;
                p += 1 + DIGEST_LANES;
            end
            else
            begin
                n_blocks++;
                p += 1 + RATE_LANES;
            end
        end
        cycle_limit = n_blocks * 32 + 200;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        tick(1'b0, 1'b0);

        p = 0;
        while (p < VEC_DEPTH && vec[p][7:0] != 8'h00)
        begin
            hdr = vec[p][7:0];
            if (hdr != 8'h01 && hdr != 8'h03)
            begin
                $display("Vector file has an unexpected record header at word %0d", p);
                abort_run();
            end
            blk.last = hdr[1];
            for (int i = 0; i < RATE_LANES; i++)
                blk.data[`SPONGE_RATE_W-1-`KECCAK_LANE_W*i -: `KECCAK_LANE_W] = vec[p+1+i];
            p += 1 + RATE_LANES;
            expected = '0;
            if (blk.last)
            begin
                if (vec[p][7:0] != 8'h02)
                begin
                    $display("Vector file has a last block with no expected digest after it");
                    abort_run();
                end
                for (int i = 0; i < DIGEST_LANES; i++)
                    expected.hash[`SPONGE_DIGEST_W-1-`KECCAK_LANE_W*i -: `KECCAK_LANE_W] =
                        vec[p+1+i];
                p += 1 + DIGEST_LANES;
            end
            send_block(blk, expected);
        end

        // The final digest pulse lasts one cycle and busy stays low.
        tick(1'b0, 1'b0);

        if (digests_expected > 0 && digests_checked == digests_expected)
        begin
            $display("Test OK");
            $finish;
        end
        else
        begin
            $display("Only %0d of %0d digests were checked", digests_checked, digests_expected);
            abort_run();
        end
    end

endmodule

// ==== verification/keccak_sponge_vectors.txt ====
// Header word, then 64-bit words of 16 hex digits, message byte 0 first. Header 1 is a block,
// 3 a last block (17 words each), 2 an expected SHA3-256 digest (4 words), 0 ends the list.
3 0600000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000080
2 a7ffc6f8bf1ed766 51c14756a061d662 f580ff4de43b49fa 82d80a4b80f8434a
3 6162630600000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000080
2 3a985da74fe225b2 045c172d6bd390bd 855f086e3e9d525b 46bfe24511431532
1 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3
3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 a3a3a3a3a3a3a3a3 0600000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000080
2 79f38adec5c20307 a98ef76e8324afbf d46cfd81b22e3973 c65fa1bd9de31787
3 6162630600000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000080
2 3a985da74fe225b2 045c172d6bd390bd 855f086e3e9d525b 46bfe24511431532
0
